//--- Makefile
VERILATOR ?= verilator
TOP ?= tbClockOverlay
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) digitFont.hex
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- clockOverlay.sv
`timescale 1ns/1ps
`default_nettype none

module clockOverlay
(
	input wire logic CLK,
	input wire logic RESET,
	input wire logic frameStart,
	output logic memRead,
	output clockOverlayPkg::fieldCode_t memAddr,
	input wire logic [7:0] memData,
	input wire logic pixelValid,
	input wire logic [9:0] posX,
	input wire logic [9:0] posY,
	output logic rgbValid,
	output clockOverlayPkg::rgb_t rgb
);

	// Committed fields, read by decode without a register in between
	clockOverlayPkg::timeFields_t fields;
	// Decode to fetch
	logic cmdValid;
	clockOverlayPkg::pixelCmd_t cmd;
	// Fetch to compose
	logic fetchValid;
	clockOverlayPkg::fetchCmd_t fetch;
	logic [7:0] glyphBits;

	timeRegBank u_bank
	(
		.CLK(CLK),
		.RESET(RESET),
		.frameStart(frameStart),
		.memRead(memRead),
		.memAddr(memAddr),
		.memData(memData),
		.fields(fields)
	);

	fieldDecode u_decode
	(
		.CLK(CLK),
		.RESET(RESET),
		.pixelValid(pixelValid),
		.posX(posX),
		.posY(posY),
		.fields(fields),
		.cmdValid(cmdValid),
		.cmd(cmd)
	);

	glyphFetch u_fetch
	(
		.CLK(CLK),
		.RESET(RESET),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.fetchValid(fetchValid),
		.fetch(fetch),
		.glyphBits(glyphBits)
	);

	pixelCompose u_compose
	(
		.CLK(CLK),
		.RESET(RESET),
		.fetchValid(fetchValid),
		.fetch(fetch),
		.glyphBits(glyphBits),
		.rgbValid(rgbValid),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- clockOverlayPkg.sv
`default_nettype none

package clockOverlayPkg;

	// 2 bits per channel, red in the top bits
	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
	} rgb_t;

	localparam rgb_t COLOR_BG = '{r: 2'b00, g: 2'b00, b: 2'b01};
	localparam rgb_t COLOR_FG = '{r: 2'b11, g: 2'b11, b: 2'b11};
	localparam rgb_t COLOR_CURSOR = '{r: 2'b11, g: 2'b11, b: 2'b00};
	localparam rgb_t COLOR_ON = '{r: 2'b00, g: 2'b11, b: 2'b00};
	localparam rgb_t COLOR_OFF = '{r: 2'b11, g: 2'b00, b: 2'b00};

	// Square glyph cells
	localparam int GLYPH_SIZE = 8;
	// Ten digits of eight rows each
	localparam int FONT_BYTES = 80;

	// Top line of each screen row
	localparam logic [9:0] ROW_DATE_Y = 10'd16;
	localparam logic [9:0] ROW_TIME_Y = 10'd40;
	localparam logic [9:0] ROW_IND_Y = 10'd64;

	// Tens digit column of each pair, units sits one cell to the right
	localparam logic [9:0] DAY_X = 10'd8;
	localparam logic [9:0] MONTH_X = 10'd32;
	localparam logic [9:0] YEAR_X = 10'd56;
	localparam logic [9:0] CLK_HOUR_X = 10'd8;
	localparam logic [9:0] CLK_MIN_X = 10'd32;
	localparam logic [9:0] CLK_SEC_X = 10'd56;
	localparam logic [9:0] SW_HOUR_X = 10'd88;
	localparam logic [9:0] SW_MIN_X = 10'd112;
	localparam logic [9:0] SW_SEC_X = 10'd136;

	// Indicator squares on the bottom row
	localparam logic [9:0] IND_RUN_X = 10'd8;
	localparam logic [9:0] IND_DONE_X = 10'd32;

	// Status memory map, a cursor code is the field code plus one
	typedef enum logic [3:0] {
		FC_CLK_SEC, FC_CLK_MIN, FC_CLK_HOUR,
		FC_DAY, FC_MONTH, FC_YEAR,
		FC_SW_SEC, FC_SW_MIN, FC_SW_HOUR,
		FC_SW_RUN, FC_SW_DONE, FC_CURSOR
	} fieldCode_t;

	localparam int NUM_FIELDS = 12;

	typedef enum logic {IDLE, SWEEP} loadState_t;

	typedef enum logic [1:0] {PK_BG, PK_DIGIT, PK_IND} pixelKind_t;

	// Committed time fields, flags reduced to one bit
	typedef struct packed {
		logic [7:0] clkSec;
		logic [7:0] clkMin;
		logic [7:0] clkHour;
		logic [7:0] day;
		logic [7:0] month;
		logic [7:0] year;
		logic [7:0] swSec;
		logic [7:0] swMin;
		logic [7:0] swHour;
		logic swRun;
		logic swDone;
		logic [7:0] cursor;
	} timeFields_t;

	// Decode stage result
	typedef struct packed {
		pixelKind_t kind;
		logic [3:0] digit;
		logic [2:0] glyphRow;
		logic [2:0] glyphCol;
		logic underline;
		logic indOn;
	} pixelCmd_t;

	// Context carried alongside the font ROM read
	typedef struct packed {
		pixelKind_t kind;
		logic [2:0] glyphCol;
		logic [2:0] glyphRow;
		logic underline;
		logic indOn;
	} fetchCmd_t;

	// One two-digit field on screen
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		fieldCode_t field;
	} pairDef_t;

	localparam int NUM_PAIRS = 9;

	localparam pairDef_t PAIRS [NUM_PAIRS] = '{
		'{x: DAY_X, y: ROW_DATE_Y, field: FC_DAY},
		'{x: MONTH_X, y: ROW_DATE_Y, field: FC_MONTH},
		'{x: YEAR_X, y: ROW_DATE_Y, field: FC_YEAR},
		'{x: CLK_HOUR_X, y: ROW_TIME_Y, field: FC_CLK_HOUR},
		'{x: CLK_MIN_X, y: ROW_TIME_Y, field: FC_CLK_MIN},
		'{x: CLK_SEC_X, y: ROW_TIME_Y, field: FC_CLK_SEC},
		'{x: SW_HOUR_X, y: ROW_TIME_Y, field: FC_SW_HOUR},
		'{x: SW_MIN_X, y: ROW_TIME_Y, field: FC_SW_MIN},
		'{x: SW_SEC_X, y: ROW_TIME_Y, field: FC_SW_SEC}
	};

endpackage

`default_nettype wire

//--- digitFont.hex
// Digits 0 to 9, eight rows each from the top, bit 7 is the leftmost pixel
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
30
60
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
3C
60
7C
66
66
66
3C
00
7E
06
0C
18
30
30
30
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
0C
38
00

//--- fieldDecode.sv
`timescale 1ns/1ps
`default_nettype none

module fieldDecode
(
	input wire logic CLK,
	input wire logic RESET,
	input wire logic pixelValid,
	input wire logic [9:0] posX,
	input wire logic [9:0] posY,
	input wire clockOverlayPkg::timeFields_t fields,
	output logic cmdValid,
	output clockOverlayPkg::pixelCmd_t cmd
);

	clockOverlayPkg::pixelCmd_t nextCmd;
	// Offset of the pixel inside the hit pair
	logic [9:0] dx;
	logic [9:0] dy;
	logic [7:0] pairByte;

	// True when pos lies in [origin, origin + size)
	function automatic logic inSpan(input logic [9:0] pos, input logic [9:0] origin,
		input int size);
		return (pos >= origin) && (pos < origin + size);
	endfunction

	// BCD byte of a displayed field
	function automatic logic [7:0] fieldByte(input clockOverlayPkg::timeFields_t f,
		input clockOverlayPkg::fieldCode_t code);
		logic [7:0] value;
		value = 8'h00;
		case (code)
			clockOverlayPkg::FC_CLK_SEC: value = f.clkSec;
			clockOverlayPkg::FC_CLK_MIN: value = f.clkMin;
			clockOverlayPkg::FC_CLK_HOUR: value = f.clkHour;
			clockOverlayPkg::FC_DAY: value = f.day;
			clockOverlayPkg::FC_MONTH: value = f.month;
			clockOverlayPkg::FC_YEAR: value = f.year;
			clockOverlayPkg::FC_SW_SEC: value = f.swSec;
			clockOverlayPkg::FC_SW_MIN: value = f.swMin;
			clockOverlayPkg::FC_SW_HOUR: value = f.swHour;
			default: value = 8'h00;
		endcase
		return value;
	endfunction

	always_comb
	begin
		nextCmd = '0;
		nextCmd.kind = clockOverlayPkg::PK_BG;
		dx = '0;
		dy = '0;
		pairByte = '0;
		// Digit pairs are two cells wide and never overlap
		for (int i = 0; i < clockOverlayPkg::NUM_PAIRS; i++)
		begin
			if (inSpan(posX, clockOverlayPkg::PAIRS[i].x, 2 * clockOverlayPkg::GLYPH_SIZE) &&
				inSpan(posY, clockOverlayPkg::PAIRS[i].y, clockOverlayPkg::GLYPH_SIZE))
			begin
				dx = posX - clockOverlayPkg::PAIRS[i].x;
				dy = posY - clockOverlayPkg::PAIRS[i].y;
				pairByte = fieldByte(fields, clockOverlayPkg::PAIRS[i].field);
				nextCmd.kind = clockOverlayPkg::PK_DIGIT;
				// Left cell is tens, right cell is units
				nextCmd.digit = dx[3] ? pairByte[3:0] : pairByte[7:4];
				nextCmd.glyphCol = dx[2:0];
				nextCmd.glyphRow = dy[2:0];
				// Bottom glyph row under the edit cursor
				nextCmd.underline = (dy[2:0] == 3'd7) &&
					(fields.cursor == 8'(clockOverlayPkg::PAIRS[i].field) + 8'd1);
			end
		end
		// Indicator squares
		if (inSpan(posY, clockOverlayPkg::ROW_IND_Y, clockOverlayPkg::GLYPH_SIZE))
		begin
			if (inSpan(posX, clockOverlayPkg::IND_RUN_X, clockOverlayPkg::GLYPH_SIZE))
			begin
				nextCmd.kind = clockOverlayPkg::PK_IND;
				nextCmd.indOn = fields.swRun;
			end
			else if (inSpan(posX, clockOverlayPkg::IND_DONE_X, clockOverlayPkg::GLYPH_SIZE))
			begin
				nextCmd.kind = clockOverlayPkg::PK_IND;
				nextCmd.indOn = fields.swDone;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			cmdValid <= 1'b0;
		else
			cmdValid <= pixelValid;
	end

	always_ff @(posedge CLK)
	begin
		cmd <= nextCmd;
	end

	// Underline belongs to digit cells only
	assert property (@(posedge CLK) disable iff (RESET)
		cmdValid && cmd.underline |-> cmd.kind == clockOverlayPkg::PK_DIGIT);

endmodule

`default_nettype wire

//--- glyphFetch.sv
`timescale 1ns/1ps
`default_nettype none

module glyphFetch
(
	input wire logic CLK,
	input wire logic RESET,
	input wire logic cmdValid,
	input wire clockOverlayPkg::pixelCmd_t cmd,
	output logic fetchValid,
	output clockOverlayPkg::fetchCmd_t fetch,
	output logic [7:0] glyphBits
);

	// Digit times eight plus row
	logic [6:0] romAddr;

	assign romAddr = {cmd.digit, cmd.glyphRow};

	glyphRom u_rom
	(
		.CLK(CLK),
		.addr(romAddr),
		.data(glyphBits)
	);

	// Context waits one cycle to meet the ROM byte
	always_ff @(posedge CLK)
	begin
		if (RESET)
			fetchValid <= 1'b0;
		else
			fetchValid <= cmdValid;
	end

	always_ff @(posedge CLK)
	begin
		fetch.kind <= cmd.kind;
		fetch.glyphCol <= cmd.glyphCol;
		fetch.glyphRow <= cmd.glyphRow;
		fetch.underline <= cmd.underline;
		fetch.indOn <= cmd.indOn;
	end

endmodule

`default_nettype wire

//--- glyphRom.sv
`timescale 1ns/1ps
`default_nettype none

module glyphRom
(
	input wire logic CLK,
	input wire logic [6:0] addr,
	output logic [7:0] data
);

	// Eight rows per digit, bit 7 is the leftmost pixel
	logic [7:0] rom [clockOverlayPkg::FONT_BYTES];

	initial
	begin
		$readmemh("digitFont.hex", rom);
	end

	// Addresses past the last digit read as blank
	always_ff @(posedge CLK)
	begin
		if (addr < 7'(clockOverlayPkg::FONT_BYTES))
			data <= rom[addr];
		else
			data <= 8'h00;
	end

endmodule

`default_nettype wire

//--- pixelCompose.sv
`timescale 1ns/1ps
`default_nettype none

module pixelCompose
(
	input wire logic CLK,
	input wire logic RESET,
	input wire logic fetchValid,
	input wire clockOverlayPkg::fetchCmd_t fetch,
	input wire logic [7:0] glyphBits,
	output logic rgbValid,
	output clockOverlayPkg::rgb_t rgb
);

	// Font pixel for this column, MSB on the left
	logic glyphOn;
	clockOverlayPkg::rgb_t nextRgb;

	assign glyphOn = glyphBits[3'd7 - fetch.glyphCol];

	always_comb
	begin
		case (fetch.kind)
			clockOverlayPkg::PK_IND:
				nextRgb = fetch.indOn ? clockOverlayPkg::COLOR_ON : clockOverlayPkg::COLOR_OFF;
			clockOverlayPkg::PK_DIGIT:
			begin
				// Cursor bar wins over the glyph
				if (fetch.underline)
					nextRgb = clockOverlayPkg::COLOR_CURSOR;
				else if (glyphOn)
					nextRgb = clockOverlayPkg::COLOR_FG;
				else
					nextRgb = clockOverlayPkg::COLOR_BG;
			end
			default: nextRgb = clockOverlayPkg::COLOR_BG;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			rgbValid <= 1'b0;
		else
			rgbValid <= fetchValid;
	end

	always_ff @(posedge CLK)
	begin
		rgb <= nextRgb;
	end

	// Decode only marks the bottom glyph row
	assert property (@(posedge CLK) disable iff (RESET)
		fetchValid && fetch.underline |-> fetch.glyphRow == 3'd7);

endmodule

`default_nettype wire

//--- src.f
clockOverlayPkg.sv
timeRegBank.sv
fieldDecode.sv
glyphRom.sv
glyphFetch.sv
pixelCompose.sv
clockOverlay.sv
tbClockOverlay.sv

//--- tbClockOverlay.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockOverlay;

	// Longest wait for any handshake, in cycles
	localparam int TIMEOUT = 50;
	localparam int BURST_LEN = 200;

	// Digit pairs, tens column first, with the status address of each field
	localparam int PAIR_X [9] = '{8, 32, 56, 8, 32, 56, 88, 112, 136};
	localparam int PAIR_Y [9] = '{16, 16, 16, 40, 40, 40, 40, 40, 40};
	localparam int PAIR_FIELD [9] = '{3, 4, 5, 2, 1, 0, 8, 7, 6};

	logic CLK;
	logic RESET;
	logic frameStart;
	logic memRead;
	clockOverlayPkg::fieldCode_t memAddr;
	logic [7:0] memData;
	logic pixelValid;
	logic [9:0] posX;
	logic [9:0] posY;
	logic rgbValid;
	clockOverlayPkg::rgb_t rgb;

	// Status memory, and the fields the screen should show after a sweep
	logic [7:0] statusMem [12];
	logic [7:0] shown [12];
	logic [7:0] font [80];
	int readCount;
	logic [31:0] seed;
	clockOverlayPkg::rgb_t lastRgb;
	// Read request seen on the previous falling edge
	logic pendingRead;
	clockOverlayPkg::fieldCode_t pendingAddr;

	clockOverlay u_dut
	(
		.CLK(CLK),
		.RESET(RESET),
		.frameStart(frameStart),
		.memRead(memRead),
		.memAddr(memAddr),
		.memData(memData),
		.pixelValid(pixelValid),
		.posX(posX),
		.posY(posY),
		.rgbValid(rgbValid),
		.rgb(rgb)
	);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// Memory answers each read one cycle later, on the following falling edge
	always @(negedge CLK)
	begin
		if (pendingRead)
			memData = statusMem[pendingAddr];
		if (memRead)
			readCount = readCount + 1;
		pendingRead = memRead;
		pendingAddr = memAddr;
	end

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [7:0] randBcd();
		logic [31:0] r;
		r = nextRand();
		return {4'((r >> 20) % 32'd10), 4'((r >> 8) % 32'd10)};
	endfunction

	// Expected colour from the screen layout and the colour priority
	function automatic clockOverlayPkg::rgb_t refColor(input int x, input int y);
		clockOverlayPkg::rgb_t result;
		int i;
		int cx;
		int cy;
		logic [7:0] value;
		logic [3:0] digit;
		logic [7:0] row;
		result = clockOverlayPkg::COLOR_BG;
		if (y >= 64 && y < 72 && x >= 8 && x < 16)
			result = shown[9][0] ? clockOverlayPkg::COLOR_ON : clockOverlayPkg::COLOR_OFF;
		if (y >= 64 && y < 72 && x >= 32 && x < 40)
			result = shown[10][0] ? clockOverlayPkg::COLOR_ON : clockOverlayPkg::COLOR_OFF;
		for (i = 0; i < 9; i++)
		begin
			if (x >= PAIR_X[i] && x < PAIR_X[i] + 16 && y >= PAIR_Y[i] && y < PAIR_Y[i] + 8)
			begin
				cx = x - PAIR_X[i];
				cy = y - PAIR_Y[i];
				value = shown[PAIR_FIELD[i]];
				digit = (cx < 8) ? value[7:4] : value[3:0];
				row = font[digit * 8 + cy];
				// Cursor code is the field address plus one
				if (cy == 7 && shown[11] == 8'(PAIR_FIELD[i] + 1))
					result = clockOverlayPkg::COLOR_CURSOR;
				else if (row[7 - cx % 8])
					result = clockOverlayPkg::COLOR_FG;
			end
		end
		return result;
	endfunction

	task automatic stopOnError();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			stopOnError();
		end
	endtask

	// One pixel in, then wait for its colour and check latency and value
	task automatic pixelCheck(input string name, input int x, input int y,
		input clockOverlayPkg::rgb_t expected);
		int cycles;
		posX = 10'(x);
		posY = 10'(y);
		pixelValid = 1'b1;
		@(negedge CLK);
		pixelValid = 1'b0;
		cycles = 1;
		while (!rgbValid && cycles < TIMEOUT)
		begin
			@(negedge CLK);
			cycles++;
		end
		if (!rgbValid)
		begin
			$display("No rgbValid within %0d cycles of the pixel at %0d,%0d", TIMEOUT, x, y);
			stopOnError();
		end
		lastRgb = rgb;
		checkValue({name, " latency"}, 32'd3, 32'(cycles));
		checkValue({name, " colour"}, 32'(expected), 32'(rgb));
	endtask

	task automatic pixelRef(input string name, input int x, input int y);
		pixelCheck(name, x, y, refColor(x, y));
	endtask

	// Every pixel of both cells of a pair
	task automatic scanPair(input string name, input int pair);
		int dx;
		int dy;
		for (dy = 0; dy < 8; dy++)
			for (dx = 0; dx < 16; dx++)
				pixelRef(name, PAIR_X[pair] + dx, PAIR_Y[pair] + dy);
	endtask

	// Waits out the end of a running sweep and the commit after it
	task automatic finishSweep(input string name);
		int cycles;
		cycles = 0;
		while (memRead && cycles < TIMEOUT)
		begin
			@(negedge CLK);
			cycles++;
		end
		if (memRead)
		begin
			$display("The memory sweep did not end within %0d cycles", TIMEOUT);
			stopOnError();
		end
		// Commit lands one cycle after the last read
		@(negedge CLK);
		checkValue({name, " reads"}, 32'd12, 32'(readCount));
		for (int i = 0; i < 12; i++)
			shown[i] = statusMem[i];
	endtask

	task automatic loadFields(input string name);
		readCount = 0;
		frameStart = 1'b1;
		@(negedge CLK);
		frameStart = 1'b0;
		if (!memRead)
		begin
			$display("No memory read in the cycle after frameStart");
			stopOnError();
		end
		finishSweep(name);
	endtask

	task automatic testReset();
		pixelCheck("reset run square", 8, 64, clockOverlayPkg::COLOR_OFF);
		pixelCheck("reset done square", 39, 71, clockOverlayPkg::COLOR_OFF);
		pixelCheck("reset background", 300, 200, clockOverlayPkg::COLOR_BG);
		// All fields zero so the hour cells show glyph 0
		scanPair("reset digit", 3);
	endtask

	task automatic testClockDate();
		int i;
		statusMem[0] = 8'h59;
		statusMem[1] = 8'h47;
		statusMem[2] = 8'h23;
		statusMem[3] = 8'h31;
		statusMem[4] = 8'h12;
		statusMem[5] = 8'h68;
		statusMem[11] = 8'h00;
		loadFields("clock date");
		for (i = 0; i < 6; i++)
			scanPair("clock date digit", i);
	endtask

	task automatic testStopwatch();
		statusMem[6] = randBcd();
		statusMem[7] = randBcd();
		statusMem[8] = randBcd();
		statusMem[9] = 8'h01;
		statusMem[10] = 8'h00;
		loadFields("stopwatch");
		scanPair("stopwatch digit", 6);
		scanPair("stopwatch digit", 7);
		scanPair("stopwatch digit", 8);
		pixelCheck("running square on", 10, 66, clockOverlayPkg::COLOR_ON);
		pixelCheck("finished square off", 34, 66, clockOverlayPkg::COLOR_OFF);
		// Only bit 0 of a flag byte counts
		statusMem[9] = 8'hFE;
		statusMem[10] = 8'h03;
		loadFields("flags");
		pixelCheck("running square off", 15, 70, clockOverlayPkg::COLOR_OFF);
		pixelCheck("finished square on", 32, 64, clockOverlayPkg::COLOR_ON);
	endtask

	task automatic testCursor();
		int c;
		int i;
		int dx;
		int hits;
		for (c = 0; c < 10; c++)
		begin
			statusMem[11] = 8'(c);
			loadFields("cursor");
			hits = 0;
			for (i = 0; i < 9; i++)
			begin
				for (dx = 0; dx < 16; dx++)
				begin
					pixelRef("cursor row", PAIR_X[i] + dx, PAIR_Y[i] + 7);
					if (lastRgb == clockOverlayPkg::COLOR_CURSOR)
						hits++;
				end
			end
			// Two cells of eight pixels, or nothing for code 0
			checkValue("cursor pixel count", (c == 0) ? 32'd0 : 32'd16, 32'(hits));
		end
	endtask

	task automatic testBurst();
		clockOverlayPkg::rgb_t expected [$];
		logic [31:0] r;
		int i;
		int x;
		int y;
		int cyc;
		for (i = 0; i < 9; i++)
			statusMem[i] = randBcd();
		r = nextRand();
		statusMem[9] = {7'd0, r[12]};
		statusMem[10] = {7'd0, r[20]};
		statusMem[11] = 8'((r >> 24) % 32'd10);
		loadFields("burst");
		// Result of the pixel sent three falling edges earlier
		for (cyc = 0; cyc < BURST_LEN + 3; cyc++)
		begin
			if (cyc >= 3)
			begin
				checkValue("burst valid", 32'd1, 32'(rgbValid));
				checkValue("burst colour", 32'(expected.pop_front()), 32'(rgb));
			end
			if (cyc < BURST_LEN)
			begin
				x = int'((nextRand() >> 8) % 32'd160);
				y = int'((nextRand() >> 8) % 32'd80);
				posX = 10'(x);
				posY = 10'(y);
				pixelValid = 1'b1;
				expected.push_back(refColor(x, y));
			end
			else
				pixelValid = 1'b0;
			@(negedge CLK);
		end
		checkValue("burst end", 32'd0, 32'(rgbValid));
	endtask

	task automatic testIgnoredStart();
		int i;
		for (i = 0; i < 9; i++)
			statusMem[i] = randBcd();
		statusMem[9] = 8'h01;
		statusMem[10] = 8'h01;
		statusMem[11] = 8'h04;
		readCount = 0;
		frameStart = 1'b1;
		@(negedge CLK);
		frameStart = 1'b0;
		repeat (4) @(negedge CLK);
		// Second start lands in the middle of the sweep
		checkValue("second start mid sweep", 32'd1, 32'(memRead));
		frameStart = 1'b1;
		@(negedge CLK);
		frameStart = 1'b0;
		finishSweep("second start");
		scanPair("first sweep day", 0);
		pixelRef("first sweep run square", 9, 65);
		// Memory changes now must never reach the screen
		for (i = 0; i < 9; i++)
			statusMem[i] = 8'h88;
		repeat (20)
		begin
			@(negedge CLK);
			checkValue("no restarted sweep", 32'd0, 32'(memRead));
		end
		checkValue("no extra reads", 32'd12, 32'(readCount));
		scanPair("fields kept", 0);
		scanPair("fields kept", 5);
	endtask

	initial
	begin
		int i;
		seed = 32'hbaebceec;
		RESET = 1'b1;
		frameStart = 1'b0;
		memData = 8'h00;
		pixelValid = 1'b0;
		posX = 10'd0;
		posY = 10'd0;
		readCount = 0;
		pendingRead = 1'b0;
		pendingAddr = clockOverlayPkg::FC_CLK_SEC;
		lastRgb = clockOverlayPkg::COLOR_BG;
		for (i = 0; i < 12; i++)
		begin
			statusMem[i] = 8'h00;
			shown[i] = 8'h00;
		end
		$readmemh("digitFont.hex", font);
		repeat (5) @(negedge CLK);
		RESET = 1'b0;
		testReset();
		testClockDate();
		testStopwatch();
		testCursor();
		testBurst();
		testIgnoredStart();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- timeRegBank.sv
`timescale 1ns/1ps
`default_nettype none

module timeRegBank
(
	input wire logic CLK,
	input wire logic RESET,
	input wire logic frameStart,
	output logic memRead,
	output clockOverlayPkg::fieldCode_t memAddr,
	input wire logic [7:0] memData,
	output clockOverlayPkg::timeFields_t fields
);

	clockOverlayPkg::loadState_t state;
	// A read went out last cycle, so memData carries its byte now
	logic rdPending;
	clockOverlayPkg::fieldCode_t rdAddr;
	// Copy being filled while the sweep runs
	clockOverlayPkg::timeFields_t shadow;
	clockOverlayPkg::timeFields_t shadowNext;
	logic lastWord;

	// Final byte of the sweep is on the bus
	assign lastWord = rdPending &&
		(rdAddr == clockOverlayPkg::fieldCode_t'(clockOverlayPkg::NUM_FIELDS - 1));

	// Merge the incoming byte so the commit can take it in the same edge
	always_comb
	begin
		shadowNext = shadow;
		if (rdPending)
		begin
			case (rdAddr)
				clockOverlayPkg::FC_CLK_SEC: shadowNext.clkSec = memData;
				clockOverlayPkg::FC_CLK_MIN: shadowNext.clkMin = memData;
				clockOverlayPkg::FC_CLK_HOUR: shadowNext.clkHour = memData;
				clockOverlayPkg::FC_DAY: shadowNext.day = memData;
				clockOverlayPkg::FC_MONTH: shadowNext.month = memData;
				clockOverlayPkg::FC_YEAR: shadowNext.year = memData;
				clockOverlayPkg::FC_SW_SEC: shadowNext.swSec = memData;
				clockOverlayPkg::FC_SW_MIN: shadowNext.swMin = memData;
				clockOverlayPkg::FC_SW_HOUR: shadowNext.swHour = memData;
				// Flags keep bit 0 only
				clockOverlayPkg::FC_SW_RUN: shadowNext.swRun = memData[0];
				clockOverlayPkg::FC_SW_DONE: shadowNext.swDone = memData[0];
				clockOverlayPkg::FC_CURSOR: shadowNext.cursor = memData;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		shadow <= shadowNext;
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state <= clockOverlayPkg::IDLE;
			memRead <= 1'b0;
			memAddr <= clockOverlayPkg::FC_CLK_SEC;
			rdPending <= 1'b0;
			rdAddr <= clockOverlayPkg::FC_CLK_SEC;
			fields <= '0;
		end
		else
		begin
			rdPending <= memRead;
			rdAddr <= memAddr;
			case (state)
				clockOverlayPkg::IDLE:
				begin
					// Start from address 0 on the next cycle
					if (frameStart)
					begin
						state <= clockOverlayPkg::SWEEP;
						memRead <= 1'b1;
						memAddr <= clockOverlayPkg::FC_CLK_SEC;
					end
				end
				clockOverlayPkg::SWEEP:
				begin
					// One read per cycle up to the cursor field
					if (memRead)
					begin
						if (memAddr == clockOverlayPkg::fieldCode_t'(clockOverlayPkg::NUM_FIELDS - 1))
							memRead <= 1'b0;
						else
							memAddr <= clockOverlayPkg::fieldCode_t'(memAddr + 4'd1);
					end
					// Whole copy goes out at once, frameStart stays ignored until here
					if (lastWord)
					begin
						fields <= shadowNext;
						state <= clockOverlayPkg::IDLE;
					end
				end
				default: state <= clockOverlayPkg::IDLE;
			endcase
		end
	end

	// Reads only happen inside a sweep
	assert property (@(posedge CLK) disable iff (RESET)
		state == clockOverlayPkg::IDLE |-> !memRead);

endmodule

`default_nettype wire
